/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = heapTb
FILELIST = build.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* build.f */
+incdir+source
source/heapPkg.sv
source/heapAllocator.sv
source/heapStore.sv
source/elementAlu.sv
source/rowSearch.sv
source/heapControl.sv
source/heapTop.sv
sim/heap_asserts.sv
sim/heapTb.sv

/* sim/heapTb.sv */
//--------------------------------------------------
// Array heap testbench with clock, reset, case-file
// stimulus, compare tasks, timeout and verdict
//--------------------------------------------------
`timescale 1ns/1ps

module heapTb;
  import heapPkg::*;

  localparam int MAX_CASES = 64;
  localparam int FIELDS    = 7;          // Words per case line

  logic        clock;
  logic        resetN;
  heapAction   action;
  arrayId      array;
  elementIndex index;
  heapData     in;
  heapData     out;
  heapData     caseWords [MAX_CASES*FIELDS];  // Flat copy of the case file
  heapError    error;
  int          caseCount;
  int          cycleCount = 0;
  int          cycleLimit = 1000;       // Replaced once cases are counted
  logic [31:0] rngState;

  heapTop u_heapTop (.clock, .resetN, .action, .array, .index, .in, .out, .error);

  bind heapTop heapAsserts u_heapAsserts (
    .clock, .resetN, .action, .out, .error,
    .allocFlags(u_heapAllocator.arrayFlag)  // Allocation flags per array
  );

  //--------------------------------------------------
  // Helpers
  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic heapData caseField(input int caseNumber, input int column);
    return caseWords[caseNumber*FIELDS + column];
  endfunction

  task automatic applyCase(input int n);
    action <= heapAction'(8'(caseField(n, 0)));
    array  <= arrayId'(caseField(n, 1));
    index  <= elementIndex'(caseField(n, 2));
    in     <= caseField(n, 3);
  endtask

  task automatic checkData(input string name, input heapData actual, input heapData expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Data compare failed");
    end
  endtask

  task automatic checkError(input string name, input heapError actual, input heapError expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %s, expected %s", $time, name,
               actual.name(), expected.name());
      $display("TEST FAILED");
      $fatal(1, "Error compare failed");
    end
  endtask

  task automatic checkCase(input int n);
    checkError($sformatf("error (case %0d)", n), error, heapError'(3'(caseField(n, 6))));
    if (caseField(n, 4) != '0) begin  // Out only when flagged
      checkData($sformatf("out (case %0d)", n), out, caseField(n, 5));
    end
  endtask

  //--------------------------------------------------
  // Clock and timeout
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;  // 8 ns period
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("TEST FAILED");
      $fatal(1, "Timeout");
    end
  end

  //--------------------------------------------------
  // Stimulus and checking
  initial begin
    int gap;
    resetN   = 1'b0;
    action   = actNone;
    array    = '0;
    index    = '0;
    in       = '0;
    rngState = 32'd86;
    $readmemh("sim/heap_cases.txt", caseWords);
    caseCount = 0;
    while (caseCount < MAX_CASES && caseField(caseCount, 0) != 16'h00ff) caseCount++;
    cycleLimit = 10 + 4 * caseCount + 20;  // Reset plus worst-case gaps and margin
    repeat (10) @(posedge clock);
    resetN <= 1'b1;
    @(posedge clock);
    applyCase(0);
    for (int n = 0; n < caseCount; n++) begin
      rngState = xorshift(rngState);
      gap      = int'(rngState[1:0]);    // 0 to 3 idle cycles
      @(posedge clock);                  // Case n executes here
      if (gap == 0 && n + 1 < caseCount) applyCase(n + 1);
      else action <= actNone;
      @(negedge clock);
      checkCase(n);
      if (gap != 0 && n + 1 < caseCount) begin
        repeat (gap) @(posedge clock);   // Idle edges
        applyCase(n + 1);                // Taken at the following edge
        @(negedge clock);
        checkCase(n);                    // Still held while idle
      end
    end
    $display("TEST OK");
    $finish;
  end

endmodule

/* sim/heap_asserts.sv */
//--------------------------------------------------
// Concurrent checks on heap out and error,
// bound into the top level
//--------------------------------------------------
`timescale 1ns/1ps

module heapAsserts (
  input logic                       clock,
  input logic                       resetN,
  input heapPkg::heapAction         action,
  input heapPkg::heapData           out,
  input heapPkg::heapError          error,
  input logic [heapPkg::ARRAYS-1:0] allocFlags  // One flag per array
);
  import heapPkg::*;

  logic actionSeen;  // Non-idle action since reset

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)                actionSeen <= 1'b0;
    else if (action != actNone) actionSeen <= 1'b1;
  end

  quietAfterReset: assert property (@(posedge clock) disable iff (!resetN)
    !actionSeen |-> error == errOk)
    else $error("error left ok before any action");

  idleHolds: assert property (@(posedge clock) disable iff (!resetN)
    action == actNone |=> $stable(out) && $stable(error))
    else $error("out or error moved during an idle cycle");

  // Returned array number must be flagged one cycle on
  allocLive: assert property (@(posedge clock) disable iff (!resetN)
    $past(action) == actAlloc && error == errOk |-> allocFlags[arrayId'(out)])
    else $error("array returned by alloc is not live");

endmodule

/* sim/heap_cases.txt */
// action array index in checkOut expectedOut expectedError, all hex
12 0 0 0000 1 0000 0
12 0 0 0000 1 0001 0
12 0 0 0000 1 0002 0
12 0 0 0000 1 0003 0
12 0 0 0000 1 0003 6
13 2 0 0000 1 0003 0
13 0 0 0000 1 0003 0
13 0 0 0000 1 0003 2
02 0 1 1234 1 0003 2
12 0 0 0000 1 0000 0
12 0 0 0000 1 0002 0
01 0 0 0000 1 0002 0
12 0 0 0000 1 0000 0
12 0 0 0000 1 0001 0
04 3 0 0000 1 0001 1
02 0 2 00a5 1 00a5 0
02 0 5 0033 1 0033 0
04 0 0 0000 1 0006 0
03 0 2 0000 1 00a5 0
03 0 6 0000 1 00a5 3
0e 1 0 0005 1 00a5 0
0e 1 0 0009 1 00a5 0
0e 1 0 0002 1 00a5 0
0e 1 0 0009 1 00a5 0
0e 1 0 0007 1 00a5 0
0e 1 0 0001 1 00a5 0
0e 1 0 0009 1 00a5 0
0e 1 0 0004 1 00a5 0
0e 1 0 0006 1 00a5 4
07 1 0 0009 1 0007 0
08 1 0 0007 1 0004 0
09 1 0 0007 1 0003 0
0f 1 0 0000 1 0004 0
0f 1 0 0000 1 0009 0
07 1 0 0009 1 0004 0
09 1 0 0007 1 0002 0
0f 1 0 0000 1 0001 0
0f 1 0 0000 1 0007 0
0f 1 0 0000 1 0009 0
0f 1 0 0000 1 0002 0
0f 1 0 0000 1 0009 0
0f 1 0 0000 1 0005 0
0f 1 0 0000 1 0005 5
14 0 2 0010 1 00b5 0
15 0 2 ffff 1 00b5 0
03 0 2 0000 1 00b4 0
16 0 5 0034 1 ffff 0
17 0 5 0001 1 ffff 0
18 0 2 0004 1 0b40 0
19 0 2 0004 1 00b4 0
1a 0 2 0000 1 0000 0
1b 0 2 0000 1 ffff 0
1e 0 2 0f0f 1 0f0f 0
1c 0 2 3030 1 3f3f 0
1d 0 2 ffff 1 c0c0 0
19 0 2 0100 1 0000 0
1a 0 2 0000 1 0001 0
03 0 2 0000 1 0001 0
ff 0 0 0000 0 0000 0

/* source/elementAlu.sv */
//-------------------------------------------------
// New element value for in-place operations
//-------------------------------------------------
`timescale 1ns/1ps

module elementAlu (
  input  heapPkg::heapAction action,
  input  heapPkg::heapData   operand,  // Current element
  input  heapPkg::heapData   in,
  output heapPkg::heapData   result    // Value written back
);
  import heapPkg::*;

  always_comb begin
    case (action)
      actAdd,
      actAddAfter:   result = operand + in;            // Wraps at data width
      actSubtract,
      actSubAfter:   result = operand - in;
      actShiftLeft:  result = operand << in;           // Full shift amount, zero past width
      actShiftRight: result = operand >> in;           // Logical
      actNotLogical: result = heapData'(operand == '0);
      actBitNot:     result = ~operand;
      actBitOr:      result = operand | in;
      actBitXor:     result = operand ^ in;
      actBitAnd:     result = operand & in;
      default:       result = operand;                 // Not an element op
    endcase
  end

endmodule

/* source/heapAllocator.sv */
//-------------------------------------------------
// Allocation flags, freed-array stack and
// high-water counter for array numbers
//-------------------------------------------------
`timescale 1ns/1ps

module heapAllocator (
  input  logic             clock,
  input  logic             resetN,
  input  logic             clearAll,      // Forget every array
  input  logic             allocate,      // Hand out nextArray
  input  logic             releaseArray,  // Return the addressed array
  input  heapPkg::arrayId  array,
  output logic             arrayUsed,     // Handed out since last clear
  output logic             arrayLive,     // Currently allocated
  output logic             exhausted,     // No array left for alloc
  output heapPkg::arrayId  nextArray      // What an alloc would get
);
  import heapPkg::*;

  localparam int COUNT_BITS = $clog2(ARRAYS) + 1;  // Counts 0 to ARRAYS

  logic [ARRAYS-1:0]     arrayFlag;          // One allocation flag per array
  arrayId                freedStack [ARRAYS]; // Freed arrays, LIFO
  logic [COUNT_BITS-1:0] stackPointer;       // Entries on the stack
  logic [COUNT_BITS-1:0] highWater;          // Arrays ever taken from the counter
  arrayId                topIndex;           // Top of stack slot

  assign topIndex  = arrayId'(stackPointer - 1'b1);
  assign arrayUsed = COUNT_BITS'(array) < highWater;  // Below high water means handed out
  assign arrayLive = arrayFlag[array];
  assign exhausted = (stackPointer == '0) && (highWater == COUNT_BITS'(ARRAYS));
  assign nextArray = (stackPointer != '0) ? freedStack[topIndex]
                                          : arrayId'(highWater);  // Reuse first

  //-------------------------------------------------
  // Control state
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      arrayFlag    <= '0;
      stackPointer <= '0;
      highWater    <= '0;
    end else if (clearAll) begin
      arrayFlag    <= '0;  // Whole heap forgotten
      stackPointer <= '0;
      highWater    <= '0;
    end else if (allocate) begin
      arrayFlag[nextArray] <= 1'b1;
      if (stackPointer != '0) stackPointer <= stackPointer - 1'b1;  // Pop freed
      else                    highWater    <= highWater + 1'b1;     // Fresh array
    end else if (releaseArray) begin
      arrayFlag[array] <= 1'b0;                                       // Own flag cleared
      stackPointer     <= stackPointer + 1'b1;
    end
  end

  // Stack storage, only live arrays get pushed so it never overflows
  always_ff @(posedge clock) begin
    if (releaseArray) freedStack[stackPointer[COUNT_BITS-2:0]] <= array;
  end

endmodule

/* source/heapControl.sv */
//-------------------------------------------------
// Action decode, legality checks, update
// strobes and registered out and error
//-------------------------------------------------
`timescale 1ns/1ps

module heapControl (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapPkg::heapAction   action,
  input  heapPkg::arrayId      array,
  input  heapPkg::elementIndex index,
  input  heapPkg::heapData     in,
  input  logic                 arrayUsed,    // From allocator
  input  logic                 arrayLive,
  input  logic                 exhausted,
  input  heapPkg::arrayId      nextArray,
  input  heapPkg::arrayRow     row,          // From store
  input  heapPkg::elementSize  currentSize,
  input  heapPkg::heapData     result,       // From ALU
  input  heapPkg::heapData     found,        // From search
  output heapPkg::heapData     out,
  output heapPkg::heapError    error,
  output logic                 clearAll,
  output logic                 allocate,
  output logic                 releaseArray,
  output logic                 writeEnable,
  output heapPkg::elementIndex writeIndex,
  output heapPkg::heapData     writeData,
  output logic                 sizeEnable,
  output heapPkg::arrayId      sizeArray,
  output heapPkg::elementSize  newSize
);
  import heapPkg::*;

  logic        validAction;  // Known, non-idle code
  logic        elementOp;    // In-place element operator
  logic        needsIndex;   // Index must be below size
  logic        legal;        // Passed every check
  heapError    errorNext;
  heapData     outNext;
  elementSize  writeSize;    // Size implied by a write
  elementIndex topIndex;     // Last live position

  assign elementOp   = action inside {[actAdd:actBitAnd]};
  assign needsIndex  = elementOp || (action == actRead);
  assign validAction = elementOp || action inside {actClear, actWrite, actRead, actSize,
                       actIndex, actLess, actGreater, actPush, actPop, actAlloc, actFree};
  assign writeSize   = elementSize'(index) + elementSize'(1);
  assign topIndex    = elementIndex'(currentSize - elementSize'(1));
  assign legal       = validAction && (errorNext == errOk);

  //-------------------------------------------------
  // Check order, lifetime first then bounds
  always_comb begin
    errorNext = errOk;
    if (action == actAlloc) begin
      if (exhausted) errorNext = errOutOfMemory;
    end else if (action != actClear) begin
      if (!arrayUsed)                                           errorNext = errNotAllocated;
      else if (!arrayLive)                                      errorNext = errFreed;
      else if (needsIndex && elementSize'(index) >= currentSize) errorNext = errOutOfBounds;
      else if (action == actPush && currentSize == elementSize'(ARRAY_LENGTH))
                                                                errorNext = errFull;
      else if (action == actPop && currentSize == '0)           errorNext = errEmpty;
    end
  end

  // Result select
  always_comb begin
    case (action)
      actWrite:                     outNext = in;
      actRead:                      outNext = row[index];
      actSize:                      outNext = heapData'(currentSize);
      actPop:                       outNext = row[topIndex];  // Element at new size
      actIndex, actLess, actGreater: outNext = found;
      actAlloc:                     outNext = heapData'(nextArray);
      actAddAfter, actSubAfter:     outNext = row[index];     // Old value
      default:                      outNext = elementOp ? result : out;
    endcase
  end

  //-------------------------------------------------
  // Update strobes, one cycle, legal ops only
  always_comb begin
    clearAll     = legal && (action == actClear);
    allocate     = legal && (action == actAlloc);
    releaseArray = legal && (action == actFree);
    writeEnable  = 1'b0;
    writeIndex   = index;
    writeData    = in;
    sizeEnable   = 1'b0;
    sizeArray    = array;
    newSize      = currentSize;
    if (legal) begin
      case (action)
        actWrite: begin
          writeEnable = 1'b1;
          if (writeSize > currentSize) begin  // Grow only
            sizeEnable = 1'b1;
            newSize    = writeSize;
          end
        end
        actPush: begin
          writeEnable = 1'b1;
          writeIndex  = elementIndex'(currentSize);  // Below length, checked
          sizeEnable  = 1'b1;
          newSize     = currentSize + elementSize'(1);
        end
        actPop: begin
          sizeEnable = 1'b1;
          newSize    = currentSize - elementSize'(1);
        end
        actAlloc: begin
          sizeEnable = 1'b1;
          sizeArray  = nextArray;  // Fresh array starts empty
          newSize    = '0;
        end
        default: begin
          writeEnable = elementOp;
          writeData   = result;
        end
      endcase
    end
  end

  // Registered results, idle holds both
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      out   <= '0;
      error <= errOk;
    end else if (validAction) begin
      error <= errorNext;
      if (errorNext == errOk) out <= outNext;  // Failed op keeps old out
    end
  end

endmodule

/* source/heapPkg.sv */
//-------------------------------------------------
// Heap package with action, error, identifier,
// index, size, data and row types
//-------------------------------------------------
`include "heap_config.svh"

package heapPkg;

  localparam int ARRAYS       = 1 << `HEAP_ADDRESS_BITS;  // Arrays in the heap
  localparam int ARRAY_LENGTH = 1 << `HEAP_INDEX_BITS;    // Elements per array

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayId;         // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0]   elementIndex;    // Position in an array
  typedef logic [`HEAP_INDEX_BITS:0]     elementSize;     // One bit wider for a full array
  typedef logic [`HEAP_DATA_BITS-1:0]    heapData;        // Element value

  //-------------------------------------------------
  // Action codes with fixed numbering
  typedef enum logic [7:0] {
    actNone       = 8'd0,   // Idle
    actClear      = 8'd1,   // Drop all arrays
    actWrite      = 8'd2,
    actRead       = 8'd3,
    actSize       = 8'd4,
    actIndex      = 8'd7,   // Last match plus one
    actLess       = 8'd8,   // Count below in
    actGreater    = 8'd9,   // Count above in
    actPush       = 8'd14,
    actPop        = 8'd15,
    actAlloc      = 8'd18,
    actFree       = 8'd19,
    actAdd        = 8'd20,
    actAddAfter   = 8'd21,  // Returns old value
    actSubtract   = 8'd22,
    actSubAfter   = 8'd23,  // Returns old value
    actShiftLeft  = 8'd24,
    actShiftRight = 8'd25,
    actNotLogical = 8'd26,
    actBitNot     = 8'd27,
    actBitOr      = 8'd28,
    actBitXor     = 8'd29,
    actBitAnd     = 8'd30
  } heapAction;

  typedef enum logic [2:0] {
    errOk, errNotAllocated, errFreed, errOutOfBounds, errFull, errEmpty, errOutOfMemory
  } heapError;

  typedef heapData arrayRow [ARRAY_LENGTH];               // All elements of one array

endpackage

/* source/heapStore.sv */
//-------------------------------------------------
// Element memory for all arrays and the
// per-array size table
//-------------------------------------------------
`timescale 1ns/1ps

module heapStore (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapPkg::arrayId      array,        // Addressed array
  input  logic                 writeEnable,
  input  heapPkg::elementIndex writeIndex,
  input  heapPkg::heapData     writeData,
  input  logic                 sizeEnable,
  input  heapPkg::arrayId      sizeArray,    // Target of size write
  input  heapPkg::elementSize  newSize,
  output heapPkg::arrayRow     row,          // Addressed array contents
  output heapPkg::elementSize  currentSize   // Addressed array size
);
  import heapPkg::*;

  heapData    memory    [ARRAYS][ARRAY_LENGTH];  // Fixed block per array
  elementSize sizeTable [ARRAYS];                // Live length per array

  //-------------------------------------------------
  // Read side, combinational
  always_comb begin
    row         = memory[array];
    currentSize = sizeTable[array];
  end

  //-------------------------------------------------
  // Element writes, always to the addressed array
  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[array][writeIndex] <= writeData;
    end
  end

  // Size table
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < ARRAYS; a++) begin
        sizeTable[a] <= '0;  // All empty
      end
    end else if (sizeEnable) begin
      sizeTable[sizeArray] <= newSize;  // Alloc targets nextArray
    end
  end

endmodule

/* source/heapTop.sv */
//-------------------------------------------------
// Array heap top level
//-------------------------------------------------
`timescale 1ns/1ps

module heapTop (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapPkg::heapAction   action,  // Level, zero is idle
  input  heapPkg::arrayId      array,
  input  heapPkg::elementIndex index,
  input  heapPkg::heapData     in,
  output heapPkg::heapData     out,
  output heapPkg::heapError    error
);
  import heapPkg::*;

  //-------------------------------------------------
  // Allocator status and commands
  logic        arrayUsed;
  logic        arrayLive;
  logic        exhausted;
  arrayId      nextArray;
  logic        clearAll;
  logic        allocate;
  logic        releaseArray;

  // Store commands and contents
  logic        writeEnable;
  elementIndex writeIndex;
  heapData     writeData;
  logic        sizeEnable;
  arrayId      sizeArray;
  elementSize  newSize;
  arrayRow     row;
  elementSize  currentSize;

  // Datapath results
  heapData     result;
  heapData     found;

  heapControl u_heapControl (
    .clock, .resetN, .action, .array, .index, .in,
    .arrayUsed, .arrayLive, .exhausted, .nextArray,
    .row, .currentSize, .result, .found,
    .out, .error,
    .clearAll, .allocate, .releaseArray,
    .writeEnable, .writeIndex, .writeData,
    .sizeEnable, .sizeArray, .newSize
  );

  heapAllocator u_heapAllocator (
    .clock, .resetN, .clearAll, .allocate, .releaseArray, .array,
    .arrayUsed, .arrayLive, .exhausted, .nextArray
  );

  heapStore u_heapStore (
    .clock, .resetN, .array,
    .writeEnable, .writeIndex, .writeData,
    .sizeEnable, .sizeArray, .newSize,
    .row, .currentSize
  );

  elementAlu u_elementAlu (
    .action, .operand(row[index]), .in, .result  // Addressed element
  );

  rowSearch u_rowSearch (
    .action, .row, .currentSize, .in, .found
  );

endmodule

/* source/heap_config.svh */
//-------------------------------------------------
// Heap sizing: array-number, element-index
// and element data widths
//-------------------------------------------------
`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

// 4 arrays of 8 elements, 16-bit data
`define HEAP_ADDRESS_BITS 2   // Array number width
`define HEAP_INDEX_BITS   3   // Element index width
`define HEAP_DATA_BITS    16  // Element width

`endif

/* source/rowSearch.sv */
//-------------------------------------------------
// Position and count searches over the live
// elements of one array
//-------------------------------------------------
`timescale 1ns/1ps

module rowSearch (
  input  heapPkg::heapAction  action,
  input  heapPkg::arrayRow    row,
  input  heapPkg::elementSize currentSize,  // Live elements
  input  heapPkg::heapData    in,           // Search key
  output heapPkg::heapData    found
);
  import heapPkg::*;

  always_comb begin
    heapData lastMatch;  // One plus last equal position
    heapData below;      // Live elements under key
    heapData above;      // Live elements over key
    lastMatch = '0;
    below     = '0;
    above     = '0;
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      if (i < currentSize) begin  // Stale slots ignored
        if (row[i] == in) lastMatch = heapData'(i + 1);
        if (row[i] <  in) below     = below + 1'b1;
        if (row[i] >  in) above     = above + 1'b1;
      end
    end
    case (action)
      actIndex:   found = lastMatch;
      actLess:    found = below;
      actGreater: found = above;
      default:    found = '0;
    endcase
  end

endmodule
